// ==== compile.f ====
+incdir+include
src/pcm_pkg.sv
src/pcm_fetch_if.sv
src/pcm_dir.sv
src/pcm_voice.sv
src/pcm_rom_arb.sv
src/pcm_mixer.sv
src/pcm_sound_top.sv
verif/pcm_rom_model.sv
verif/tb_pcm_sound.sv

// ==== include/pcm_params.svh ====
// PCM sound block parameters
`ifndef PCM_PARAMS_SVH
`define PCM_PARAMS_SVH

// Number of playback voices
`define PCM_CH 4

// Sample ROM address width
`define PCM_AW 17

// Directory PROM address width, 256 entries of 4 bytes
`define PCM_DIR_AW 10

`endif

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_pcm_sound -f compile.f -o sim_pcm \
    && ./obj_dir/sim_pcm > sim.log 2>&1
grep -q "^Regression passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src/pcm_dir.sv ====
// PCM directory and command dispatcher
`include "pcm_params.svh"

module pcm_dir (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   soft_rst_n_i,
    input  logic [`PCM_DIR_AW-1:0] prog_addr_i,
    input  logic [7:0]             prog_data_i,
    input  logic                   prom_we_i,
    input  logic                   cmd_we_i,
    input  logic [1:0]             cmd_ch_i,
    input  logic [7:0]             cmd_sample_i,
    output logic                   cmd_ready_o,
    output logic [`PCM_CH-1:0]     start_o,
    output pcm_pkg::dir_entry_t    entry_o
);

    logic [7:0]             prom [2**`PCM_DIR_AW];
    logic [7:0]             prom_q;
    logic [`PCM_DIR_AW-1:0] rd_addr;
    logic                   busy_r;
    logic [2:0]             step_r;   // Next byte index, 4 means assemble
    logic [1:0]             ch_r;
    logic [7:0]             sample_r;
    logic [7:0]             b0_r;
    logic [7:0]             b1_r;
    logic [7:0]             b2_r;
    logic                   accept;
    pcm_pkg::dir_entry_t    entry_nxt;

    assign accept      = cmd_we_i & ~busy_r;
    assign cmd_ready_o = ~busy_r;

    // Byte 0 is addressed straight from the command so the read starts at once
    assign rd_addr = busy_r ? {sample_r, step_r[1:0]} : {cmd_sample_i, 2'd0};

    always_ff @(posedge clk) begin
        if (prom_we_i) begin
            prom[prog_addr_i] <= prog_data_i;
        end
        prom_q <= prom[rd_addr];
    end

    // Byte 3 is used directly from the PROM output
    always_comb begin
        entry_nxt.start = {b2_r[0], b1_r, b0_r};
        entry_nxt.vol   = b2_r[7:5];
        entry_nxt.len   = prom_q;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ch_r     <= cmd_ch_i;
            sample_r <= cmd_sample_i;
        end
        if (busy_r) begin
            case (step_r)
                3'd1:    b0_r <= prom_q;
                3'd2:    b1_r <= prom_q;
                3'd3:    b2_r <= prom_q;
                3'd4:    entry_o <= entry_nxt;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_r  <= 1'b0;
            step_r  <= 3'd0;
            start_o <= '0;
        end else if (!soft_rst_n_i) begin
            busy_r  <= 1'b0;
            step_r  <= 3'd0;
            start_o <= '0;
        end else begin
            start_o <= '0;
            if (accept) begin
                busy_r <= 1'b1;
                step_r <= 3'd1;
            end else if (busy_r) begin
                if (step_r == 3'd4) begin
                    busy_r <= 1'b0;
                    if (entry_nxt.len != 8'd0) begin
                        start_o <= {{(`PCM_CH-1){1'b0}}, 1'b1} << ch_r;
                    end
                end else begin
                    step_r <= step_r + 3'd1;
                end
            end
        end
    end

endmodule

// ==== src/pcm_fetch_if.sv ====
// Voice ROM fetch channel
`include "pcm_params.svh"

interface pcm_fetch_if;

    logic               req;   // Level, held with addr until ack
    logic [`PCM_AW-1:0] addr;
    logic               ack;   // One-cycle pulse
    logic [7:0]         data;  // Valid in the ack cycle

    modport voice (
        output req,
        output addr,
        input  ack,
        input  data
    );

    modport arbiter (
        input  req,
        input  addr,
        output ack,
        output data
    );

endinterface

// ==== src/pcm_mixer.sv ====
// Voice mixer with saturation
`include "pcm_params.svh"

module pcm_mixer (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              cen_pcm_i,
    input  logic signed [7:0] samples_i [`PCM_CH],
    output logic signed [7:0] snd_o
);

    localparam int SW = 8 + $clog2(`PCM_CH);
    localparam logic signed [SW-1:0] SUM_MAX = 127;
    localparam logic signed [SW-1:0] SUM_MIN = -128;

    logic signed [SW-1:0] sum;
    logic signed [7:0]    clamped;

    // Wide enough that all voices at full scale cannot overflow
    always_comb begin
        sum = '0;
        for (int i = 0; i < `PCM_CH; i++) begin
            sum = sum + samples_i[i];
        end
    end

    always_comb begin
        if (sum > SUM_MAX) begin
            clamped = 8'sd127;
        end else if (sum < SUM_MIN) begin
            clamped = -8'sd128;
        end else begin
            clamped = sum[7:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            snd_o <= '0;
        end else if (cen_pcm_i) begin
            snd_o <= clamped;  // Updated once per sample tick
        end
    end

endmodule

// ==== src/pcm_pkg.sv ====
// PCM sound shared types
`include "pcm_params.svh"

package pcm_pkg;

    // Voice playback states
    typedef enum logic [1:0] {
        IDLE,   // Silent, waiting for a start
        FETCH,  // ROM byte requested
        HOLD    // Byte held until next tick
    } voice_state_e;

    // Directory entry as assembled from four PROM bytes
    //   byte 0 : start[7:0]
    //   byte 1 : start[15:8]
    //   byte 2 : start[16] in bit 0, volume in bits 7..5
    //   byte 3 : length in bytes
    typedef struct packed {
        logic [`PCM_AW-1:0] start;  // First sample address
        logic [2:0]         vol;    // 7 is unity gain
        logic [7:0]         len;    // Zero means no start
    } dir_entry_t;

endpackage

// ==== src/pcm_rom_arb.sv ====
// Sample ROM round-robin arbiter
`include "pcm_params.svh"

module pcm_rom_arb (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic [7:0]         pcm_data_i,
    input  logic               pcm_ok_i,
    pcm_fetch_if.arbiter       fetch [`PCM_CH],
    output logic [`PCM_AW-1:0] pcm_addr_o,
    output logic               pcm_cs_o
);

    localparam int IW = $clog2(`PCM_CH);

    logic [`PCM_CH-1:0] req_v;
    logic [`PCM_CH-1:0] req_eff;
    logic [`PCM_CH-1:0] ack_r;
    logic [`PCM_AW-1:0] addr_v [`PCM_CH];
    logic [7:0]         data_r;
    logic [IW-1:0]      ptr_r;   // Last voice served
    logic [IW-1:0]      sel_r;   // Voice owning the ROM cycle
    logic [IW-1:0]      cand;
    logic [IW-1:0]      pick;
    logic               found;

    for (genvar i = 0; i < `PCM_CH; i++) begin : g_port
        assign req_v[i]       = fetch[i].req;
        assign addr_v[i]      = fetch[i].addr;
        assign fetch[i].ack   = ack_r[i];
        assign fetch[i].data  = data_r;
    end

    // Voice just acked still shows req for one cycle
    assign req_eff = req_v & ~ack_r;

    // Search starts one past the last served voice
    always_comb begin
        found = 1'b0;
        pick  = ptr_r;
        cand  = ptr_r;
        for (int i = 1; i <= `PCM_CH; i++) begin
            cand = IW'((int'(ptr_r) + i) % `PCM_CH);
            if (!found && req_eff[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!pcm_cs_o && found) begin
            pcm_addr_o <= addr_v[pick];
        end
        if (pcm_cs_o && pcm_ok_i) begin
            data_r <= pcm_data_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pcm_cs_o <= 1'b0;
            ack_r    <= '0;
            ptr_r    <= IW'(`PCM_CH - 1);  // Voice 0 goes first
            sel_r    <= '0;
        end else begin
            ack_r <= '0;
            if (pcm_cs_o) begin
                if (pcm_ok_i) begin
                    pcm_cs_o     <= 1'b0;
                    ack_r[sel_r] <= 1'b1;
                    ptr_r        <= sel_r;
                end
            end else if (found) begin
                pcm_cs_o <= 1'b1;
                sel_r    <= pick;
            end
        end
    end

endmodule

// ==== src/pcm_sound_top.sv ====
// PCM sample playback sound block
`include "pcm_params.svh"

module pcm_sound_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   cen_pcm_i,
    input  logic                   soft_rst_n_i,
    // Directory PROM download
    input  logic [`PCM_DIR_AW-1:0] prog_addr_i,
    input  logic [7:0]             prog_data_i,
    input  logic                   prom_we_i,
    // Host commands
    input  logic                   cmd_we_i,
    input  logic [1:0]             cmd_ch_i,
    input  logic [7:0]             cmd_sample_i,
    output logic                   cmd_ready_o,
    output logic [`PCM_CH-1:0]     busy_o,
    // Sample ROM
    output logic [`PCM_AW-1:0]     pcm_addr_o,
    output logic                   pcm_cs_o,
    input  logic [7:0]             pcm_data_i,
    input  logic                   pcm_ok_i,
    // Sound output
    output logic signed [7:0]      snd_o
);

    logic [`PCM_CH-1:0]  start;
    pcm_pkg::dir_entry_t entry;
    logic signed [7:0]   samples [`PCM_CH];

    pcm_fetch_if fetch_if [`PCM_CH] ();

    pcm_dir u_dir (
        .clk          ( clk          ),
        .arst_n_i     ( arst_n_i     ),
        .soft_rst_n_i ( soft_rst_n_i ),
        .prog_addr_i  ( prog_addr_i  ),
        .prog_data_i  ( prog_data_i  ),
        .prom_we_i    ( prom_we_i    ),
        .cmd_we_i     ( cmd_we_i     ),
        .cmd_ch_i     ( cmd_ch_i     ),
        .cmd_sample_i ( cmd_sample_i ),
        .cmd_ready_o  ( cmd_ready_o  ),
        .start_o      ( start        ),
        .entry_o      ( entry        )
    );

    for (genvar g = 0; g < `PCM_CH; g++) begin : g_voice
        pcm_voice u_voice (
            .clk          ( clk          ),
            .arst_n_i     ( arst_n_i     ),
            .soft_rst_n_i ( soft_rst_n_i ),
            .cen_pcm_i    ( cen_pcm_i    ),
            .start_i      ( start[g]     ),
            .entry_i      ( entry        ),
            .fetch        ( fetch_if[g]  ),
            .busy_o       ( busy_o[g]    ),
            .sample_o     ( samples[g]   )
        );
    end

    pcm_rom_arb u_arb (
        .clk        ( clk        ),
        .arst_n_i   ( arst_n_i   ),
        .pcm_data_i ( pcm_data_i ),
        .pcm_ok_i   ( pcm_ok_i   ),
        .fetch      ( fetch_if   ),
        .pcm_addr_o ( pcm_addr_o ),
        .pcm_cs_o   ( pcm_cs_o   )
    );

    pcm_mixer u_mixer (
        .clk       ( clk       ),
        .arst_n_i  ( arst_n_i  ),
        .cen_pcm_i ( cen_pcm_i ),
        .samples_i ( samples   ),
        .snd_o     ( snd_o     )
    );

endmodule

// ==== src/pcm_voice.sv ====
// PCM playback voice
`include "pcm_params.svh"

module pcm_voice (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                soft_rst_n_i,
    input  logic                cen_pcm_i,
    input  logic                start_i,
    input  pcm_pkg::dir_entry_t entry_i,
    pcm_fetch_if.voice          fetch,
    output logic                busy_o,
    output logic signed [7:0]   sample_o
);

    pcm_pkg::voice_state_e state_r;
    logic [`PCM_AW-1:0]    addr_r;
    logic [7:0]            cnt_r;         // Bytes still to fetch
    logic [2:0]            vol_r;
    logic                  pend_r;        // Restart waiting for ack
    pcm_pkg::dir_entry_t   pend_entry_r;
    pcm_pkg::dir_entry_t   load_entry;
    logic                  in_fetch;
    logic                  got_ack;
    logic                  defer;
    logic                  load;
    logic                  take;
    logic signed [7:0]     rom_s;
    logic signed [4:0]     gain;
    logic signed [11:0]    scaled;

    assign in_fetch = (state_r == pcm_pkg::FETCH);
    assign got_ack  = in_fetch & fetch.ack;

    // A start during an open fetch waits, the ROM request must stay steady
    assign defer      = start_i & in_fetch & ~fetch.ack;
    assign load       = (start_i & (~in_fetch | fetch.ack)) | (got_ack & pend_r);
    assign load_entry = start_i ? entry_i : pend_entry_r;
    assign take       = got_ack & ~load;

    // Offset binary to signed, then volume 0..7 as gain 1/8..8/8
    assign rom_s  = {~fetch.data[7], fetch.data[6:0]};
    assign gain   = {2'b00, vol_r} + 5'sd1;
    assign scaled = (rom_s * gain) >>> 3;

    assign fetch.addr = addr_r;
    assign busy_o     = (state_r != pcm_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (defer) begin
            pend_entry_r <= entry_i;
        end
        if (load) begin
            addr_r <= load_entry.start;
            cnt_r  <= load_entry.len;
            vol_r  <= load_entry.vol;
        end else if (take) begin
            addr_r <= addr_r + 1'b1;
            cnt_r  <= cnt_r - 8'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_r   <= pcm_pkg::IDLE;
            fetch.req <= 1'b0;
            pend_r    <= 1'b0;
            sample_o  <= '0;
        end else if (!soft_rst_n_i) begin
            state_r   <= pcm_pkg::IDLE;
            fetch.req <= 1'b0;
            pend_r    <= 1'b0;
            sample_o  <= '0;
        end else begin
            if (defer) begin
                pend_r <= 1'b1;
            end
            if (got_ack) begin
                fetch.req <= 1'b0;
                pend_r    <= 1'b0;
            end
            if (load) begin
                state_r <= pcm_pkg::HOLD;  // Old sample stays until first byte
            end else begin
                case (state_r)
                    pcm_pkg::HOLD: begin
                        if (cen_pcm_i) begin
                            if (cnt_r == 8'd0) begin
                                state_r  <= pcm_pkg::IDLE;
                                sample_o <= '0;
                            end else begin
                                state_r   <= pcm_pkg::FETCH;
                                fetch.req <= 1'b1;
                            end
                        end
                    end
                    pcm_pkg::FETCH: begin
                        if (fetch.ack) begin
                            state_r  <= pcm_pkg::HOLD;
                            sample_o <= scaled[7:0];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== verif/pcm_rom_model.sv ====
// Sample ROM model
`include "pcm_params.svh"

module pcm_rom_model (
    input  logic               clk,
    input  logic               cs_i,
    input  logic [`PCM_AW-1:0] addr_i,
    output logic [7:0]         data_o,
    output logic               ok_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int                 seed = 9;
    logic [1:0]         wait_r;
    logic [`PCM_AW-1:0] addr_q;

    // Low address byte plus an offset for the upper region
    assign data_o = addr_i[7:0] + (addr_i[`PCM_AW-1] ? 8'h40 : 8'h00);

    initial begin
        ok_o   = 1'b0;
        wait_r = 2'd0;
        addr_q = '0;
    end

    always @(posedge clk) begin
        addr_q <= addr_i;
        if (!cs_i || addr_i != addr_q || ok_o) begin
            ok_o   <= 1'b0;
            wait_r <= 2'($random(seed));  // New latency per access
        end else if (wait_r == 2'd0) begin
            ok_o <= 1'b1;
        end else begin
            wait_r <= wait_r - 2'd1;
        end
    end

endmodule

// ==== verif/tb_pcm_sound.sv ====
// PCM sound block testbench
`include "pcm_params.svh"

module tb_pcm_sound;

    timeunit 1ns;
    timeprecision 1ps;

    // Ticks per test: ramps 10 + 10, mixing 28, end of sample 8, pacing 10
    localparam int TEST_TICKS = 66;
    localparam int LIMIT      = (TEST_TICKS + 4) * 16 * 2;

    logic clk = 1'b0;
    logic arst_n_i, cen_pcm_i, soft_rst_n_i, prom_we_i, cmd_we_i, pcm_cs_o, pcm_ok_i;
    logic [`PCM_DIR_AW-1:0] prog_addr_i;
    logic [7:0]             prog_data_i, cmd_sample_i, pcm_data_i;
    logic [1:0]             cmd_ch_i;
    logic                   cmd_ready_o;
    logic [`PCM_CH-1:0]     busy_o;
    logic [`PCM_AW-1:0]     pcm_addr_o;
    logic signed [7:0]      snd_o;
    logic [3:0]             tick_cnt;
    int errors = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int cycles = 0;

    pcm_sound_top dut_i (.*);

    pcm_rom_model u_rom (
        .clk(clk), .cs_i(pcm_cs_o), .addr_i(pcm_addr_o), .data_o(pcm_data_i), .ok_o(pcm_ok_i)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        tick_cnt  <= tick_cnt + 4'd1;
        cen_pcm_i <= (tick_cnt == 4'd15);  // One pulse every 16 clocks
        cycles    <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Regression failed");
            $display("Timeout after %0d cycles", cycles);
            $finish;
        end
    end

    function automatic logic [7:0] rom_byte(input logic [`PCM_AW-1:0] a);
        return a[7:0] + (a[`PCM_AW-1] ? 8'h40 : 8'h00);
    endfunction

    // Offset binary to signed, gain (vol+1)/8
    function automatic logic [7:0] expect_sample(input logic [7:0] b, input logic [2:0] vol);
        logic signed [7:0] s;
        int                p;
        s = signed'({~b[7], b[6:0]});
        p = int'(s) * (int'(vol) + 1);
        return 8'(p >>> 3);
    endfunction

    task automatic check(input string sig, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: FAILED", name);
            tests_bad++;
        end
    endtask

    task automatic wait_tick();
        @(posedge clk iff cen_pcm_i);
        @(negedge clk);
    endtask

    task automatic write_entry(input int idx, input logic [16:0] start, input logic [2:0] vol,
                               input logic [7:0] len);
        logic [7:0] bytes [4];
        bytes = '{start[7:0], start[15:8], {vol, 4'd0, start[16]}, len};
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            prom_we_i   <= 1'b1;
            prog_addr_i <= `PCM_DIR_AW'(idx * 4 + i);
            prog_data_i <= bytes[i];
        end
        @(posedge clk);
        prom_we_i <= 1'b0;
    endtask

    task automatic preload();
        write_entry(1, 17'h00090, 3'd7, 8'd6);
        write_entry(2, 17'h00090, 3'd3, 8'd6);
        write_entry(3, 17'h000E4, 3'd7, 8'd8);   // Signed +100 upward
        write_entry(4, 17'h0001C, 3'd7, 8'd8);   // Signed -100 upward
        write_entry(5, 17'h00090, 3'd7, 8'd3);
        write_entry(6, 17'h00090, 3'd7, 8'd0);
        write_entry(7, 17'h10000, 3'd7, 8'd40);  // Long sample in upper region
    endtask

    task automatic send_cmd(input logic [1:0] ch, input logic [7:0] smp);
        @(negedge clk iff cmd_ready_o);
        @(posedge clk);
        cmd_we_i     <= 1'b1;
        cmd_ch_i     <= ch;
        cmd_sample_i <= smp;
        @(posedge clk);
        cmd_we_i <= 1'b0;
    endtask

    task automatic ramp_test(input string name, input logic [7:0] smp, input logic [2:0] vol);
        logic [7:0] seen [$];
        int         e0;
        e0 = errors;
        send_cmd(2'd0, smp);
        repeat (10) begin
            wait_tick();
            seen.push_back(snd_o);
        end
        while (seen.size() > 0 && seen[0] == 8'd0) begin
            void'(seen.pop_front());
        end
        for (int i = 0; i < 6; i++) begin
            if (seen.size() <= i) begin
                $display("Output sequence ended after %0d samples", i);
                errors++;
            end else begin
                check($sformatf("snd_o[%0d]", i), seen[i],
                      expect_sample(rom_byte(17'h00090 + 17'(i)), vol));
            end
        end
        // Last ROM access is the final byte of the sample
        if (pcm_addr_o !== 17'h00090 + 17'd5) begin
            $display("CHECK FAILED pcm_addr_o got %h expected %h",
                     pcm_addr_o, 17'h00090 + 17'd5);
            errors++;
        end
        check("busy_o", {4'd0, busy_o}, 8'd0);
        report(name, e0);
    endtask

    task automatic mix_test(input logic [7:0] smp, input logic [7:0] exp);
        for (int c = 0; c < 4; c++) begin
            send_cmd(2'(c), smp);
        end
        @(negedge clk iff busy_o == 4'hF);
        wait_tick();
        wait_tick();
        check("snd_o", snd_o, exp);
        @(negedge clk iff busy_o == 4'h0);
        wait_tick();
    endtask

    task automatic end_test();
        int e0;
        bit seen_busy;
        e0 = errors;
        send_cmd(2'd0, 8'd5);
        @(negedge clk iff busy_o[0]);
        @(negedge clk iff !busy_o[0]);
        // Third byte is on the output in the tick that stops the voice
        check("snd_o", snd_o, expect_sample(rom_byte(17'h00092), 3'd7));
        wait_tick();
        check("snd_o", snd_o, 8'd0);
        seen_busy = 1'b0;
        send_cmd(2'd0, 8'd6);
        repeat (20) begin
            @(negedge clk);
            seen_busy = seen_busy | busy_o[0];
        end
        if (seen_busy) begin
            $display("Zero-length entry started channel 0");
            errors++;
        end
        report("end of sample", e0);
    endtask

    task automatic pacing_test();
        int e0;
        e0 = errors;
        send_cmd(2'd1, 8'd7);
        @(negedge clk);
        check("cmd_ready_o", {7'd0, cmd_ready_o}, 8'd0);
        @(posedge clk);
        cmd_we_i     <= 1'b1;  // Must be dropped
        cmd_ch_i     <= 2'd2;
        cmd_sample_i <= 8'd1;
        @(posedge clk);
        cmd_we_i <= 1'b0;
        repeat (3) wait_tick();
        check("busy_o", {4'd0, busy_o}, 8'h02);
        @(posedge clk);
        soft_rst_n_i <= 1'b0;
        wait_tick();  // Mixer output follows only on a tick
        check("busy_o", {4'd0, busy_o}, 8'd0);
        check("pcm_cs_o", {7'd0, pcm_cs_o}, 8'd0);
        check("snd_o", snd_o, 8'd0);
        @(posedge clk);
        soft_rst_n_i <= 1'b1;
        report("pacing and soft reset", e0);
    endtask

    initial begin
        int e0;
        arst_n_i     = 1'b0;
        soft_rst_n_i = 1'b1;
        tick_cnt     = 4'd0;
        cen_pcm_i    = 1'b0;
        prom_we_i    = 1'b0;
        prog_addr_i  = '0;
        prog_data_i  = 8'd0;
        cmd_we_i     = 1'b0;
        cmd_ch_i     = 2'd0;
        cmd_sample_i = 8'd0;
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        e0 = errors;
        check("cmd_ready_o", {7'd0, cmd_ready_o}, 8'd1);
        check("busy_o", {4'd0, busy_o}, 8'd0);
        check("pcm_cs_o", {7'd0, pcm_cs_o}, 8'd0);
        check("snd_o", snd_o, 8'd0);
        report("reset", e0);
        preload();

        ramp_test("unity gain", 8'd1, 3'd7);
        ramp_test("volume", 8'd2, 3'd3);

        e0 = errors;
        mix_test(8'd3, 8'h7F);
        mix_test(8'd4, 8'h80);
        report("mixing", e0);

        end_test();
        pacing_test();

        $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
